//--- hdl/data_ram.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module data_ram (
  input logic clock,
  input logic reset,
  dmem_if.responder dmem
);

  localparam int count_width = (`MEM_WAIT_CYCLES > 0) ? $clog2(`MEM_WAIT_CYCLES + 1) : 1;
  localparam int index_width = $clog2(`MEM_DEPTH_WORDS);

  mem_stage_pkg::xlen_t mem [`MEM_DEPTH_WORDS];
  logic [count_width-1:0] count;
  logic [index_width-1:0] index;

  initial begin
    mem = '{default: '0};
  end

  assign index = dmem.addr[index_width+1:2]; // word address, wraps at the depth

  // ready comes once valid has been held for the wait cycles
  assign dmem.ready = dmem.valid & (count == count_width'(`MEM_WAIT_CYCLES));
  assign dmem.rdata = mem[index];

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      count <= '0;
    end else if (~dmem.valid | dmem.ready) begin
      count <= '0; // a dropped request starts over
    end else begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (dmem.ready) begin
      for (int b = 0; b < `MEM_XLEN/8; b++) begin
        if (dmem.strobe[b]) begin
          mem[index][8*b +: 8] <= dmem.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- hdl/dmem_if.sv
`timescale 1ns/1ps

interface dmem_if;

  logic valid;
  mem_stage_pkg::addr_t addr;
  mem_stage_pkg::xlen_t wdata;
  mem_stage_pkg::strobe_t strobe; // zero strobe is a read
  mem_stage_pkg::xlen_t rdata;
  logic ready; // one cycle pulse, rdata valid with it

  modport requester (
    output valid, addr, wdata, strobe,
    input rdata, ready
  );

  modport responder (
    input valid, addr, wdata, strobe,
    output rdata, ready
  );

endinterface

//--- hdl/load_store_align.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module load_store_align (
  input mem_stage_pkg::slot_t slot,
  input mem_stage_pkg::xlen_t rdata,
  output mem_stage_pkg::strobe_t strobe,
  output mem_stage_pkg::xlen_t wdata,
  output mem_stage_pkg::xlen_t ldata
);

  logic [1:0] lane;
  logic [7:0] byte_sel;
  logic [15:0] half_sel;

  assign lane = slot.address[1:0];
  assign byte_sel = rdata[{lane, 3'b000} +: 8];
  assign half_sel = rdata[{lane[1], 4'b0000} +: 16]; // misaligned halves fall back to lane 0 or 2

  always_comb begin
    strobe = '0;
    wdata = slot.data;
    case (slot.op)
      mem_stage_pkg::op_sb: begin
        strobe = mem_stage_pkg::strobe_t'(4'b0001) << lane;
        wdata = {(`MEM_XLEN/8){slot.data[7:0]}}; // same byte on every lane
      end
      mem_stage_pkg::op_sh: begin
        strobe = mem_stage_pkg::strobe_t'(4'b0011) << {lane[1], 1'b0};
        wdata = {(`MEM_XLEN/16){slot.data[15:0]}};
      end
      mem_stage_pkg::op_sw: begin
        strobe = '1;
      end
      default: begin
        strobe = '0; // loads and alu ops leave the strobe at zero
      end
    endcase
  end

  always_comb begin
    case (slot.op)
      mem_stage_pkg::op_lb: begin
        ldata = {{(`MEM_XLEN-8){byte_sel[7]}}, byte_sel};
      end
      mem_stage_pkg::op_lbu: begin
        ldata = {{(`MEM_XLEN-8){1'b0}}, byte_sel};
      end
      mem_stage_pkg::op_lh: begin
        ldata = {{(`MEM_XLEN-16){half_sel[15]}}, half_sel};
      end
      mem_stage_pkg::op_lhu: begin
        ldata = {{(`MEM_XLEN-16){1'b0}}, half_sel};
      end
      default: begin
        ldata = rdata; // whole word for lw
      end
    endcase
  end

endmodule

//--- hdl/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// data path and byte address width
`define MEM_XLEN 32

// number of integer registers, x0 included
`define MEM_REGS 32

// data memory size in words, a power of two so the index wraps
`define MEM_DEPTH_WORDS 256

// cycles the data memory waits with valid held before it raises ready
`define MEM_WAIT_CYCLES 2

`endif

//--- hdl/mem_stage_pkg.sv
`include "mem_settings.svh"

package mem_stage_pkg;

  typedef logic [`MEM_XLEN-1:0] xlen_t;
  typedef logic [`MEM_XLEN-1:0] addr_t;
  typedef logic [$clog2(`MEM_REGS)-1:0] reg_addr_t;
  typedef logic [`MEM_XLEN/8-1:0] strobe_t;

  // loads and stores are kept contiguous so ranges can test for them
  typedef enum logic [3:0] {
    op_none,
    op_alu,
    op_lb,
    op_lh,
    op_lw,
    op_lbu,
    op_lhu,
    op_sb,
    op_sh,
    op_sw
  } mem_op_t;

  typedef struct packed {
    mem_op_t op;
    reg_addr_t waddr;
    addr_t address;
    xlen_t data; // alu result or store data
  } slot_t;

  typedef struct packed {
    logic wren;
    reg_addr_t waddr;
    xlen_t wdata;
  } reg_write_t;

  typedef enum logic {
    st_idle,
    st_wait
  } stage_state_t;

endpackage

//--- hdl/mem_subsystem_top.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsystem_top (
  input logic clock,
  input logic reset,
  input logic [$bits(mem_stage_pkg::mem_op_t)-1:0] slot0_op,
  input logic [$clog2(`MEM_REGS)-1:0] slot0_waddr,
  input logic [`MEM_XLEN-1:0] slot0_address,
  input logic [`MEM_XLEN-1:0] slot0_data,
  input logic [$bits(mem_stage_pkg::mem_op_t)-1:0] slot1_op,
  input logic [$clog2(`MEM_REGS)-1:0] slot1_waddr,
  input logic [`MEM_XLEN-1:0] slot1_address,
  input logic [`MEM_XLEN-1:0] slot1_data,
  input logic clear,
  input logic [$clog2(`MEM_REGS)-1:0] rd_addr,
  output logic stall,
  output logic [`MEM_XLEN-1:0] rd_data
);

  mem_stage_pkg::slot_t slot0;
  mem_stage_pkg::slot_t slot1;
  mem_stage_pkg::reg_write_t write0;
  mem_stage_pkg::reg_write_t write1;

  dmem_if dmem ();

  assign slot0 = '{op: mem_stage_pkg::mem_op_t'(slot0_op), waddr: slot0_waddr,
                   address: slot0_address, data: slot0_data};
  assign slot1 = '{op: mem_stage_pkg::mem_op_t'(slot1_op), waddr: slot1_waddr,
                   address: slot1_address, data: slot1_data};

  memory_stage i_memory_stage (
    .clock(clock),
    .reset(reset),
    .slot0(slot0),
    .slot1(slot1),
    .clear(clear),
    .dmem(dmem.requester),
    .write0(write0),
    .write1(write1),
    .stall(stall)
  );

  data_ram i_data_ram (
    .clock(clock),
    .reset(reset),
    .dmem(dmem.responder)
  );

  register_file i_register_file (
    .clock(clock),
    .reset(reset),
    .write0(write0),
    .write1(write1),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input logic clock,
  input logic reset,
  input mem_stage_pkg::slot_t slot0,
  input mem_stage_pkg::slot_t slot1,
  input logic clear,
  dmem_if.requester dmem,
  output mem_stage_pkg::reg_write_t write0,
  output mem_stage_pkg::reg_write_t write1,
  output logic stall
);

  mem_stage_pkg::stage_state_t state;
  mem_stage_pkg::stage_state_t state_next;
  mem_stage_pkg::strobe_t strobe0;
  mem_stage_pkg::strobe_t strobe1;
  mem_stage_pkg::xlen_t wdata0;
  mem_stage_pkg::xlen_t wdata1;
  mem_stage_pkg::xlen_t ldata0;
  mem_stage_pkg::xlen_t ldata1;
  mem_stage_pkg::addr_t req_addr;
  mem_stage_pkg::xlen_t req_wdata;
  mem_stage_pkg::strobe_t req_strobe;
  logic mem0;
  logic mem1;
  logic mem_present;
  logic complete;

  function automatic logic is_load(mem_stage_pkg::mem_op_t op);
    return op inside {[mem_stage_pkg::op_lb : mem_stage_pkg::op_lhu]};
  endfunction

  function automatic logic is_mem(mem_stage_pkg::mem_op_t op);
    return op inside {[mem_stage_pkg::op_lb : mem_stage_pkg::op_sw]};
  endfunction

  // result of one slot, written only on the edge that completes the pair
  function automatic mem_stage_pkg::reg_write_t build_write(
    mem_stage_pkg::slot_t slot,
    mem_stage_pkg::xlen_t ldata,
    logic enable
  );
    mem_stage_pkg::reg_write_t w;
    w.waddr = slot.waddr;
    w.wdata = (slot.op == mem_stage_pkg::op_alu) ? slot.data : ldata;
    w.wren = enable & ((slot.op == mem_stage_pkg::op_alu) | is_load(slot.op));
    return w;
  endfunction

  load_store_align i_align0 (
    .slot(slot0),
    .rdata(dmem.rdata),
    .strobe(strobe0),
    .wdata(wdata0),
    .ldata(ldata0)
  );

  load_store_align i_align1 (
    .slot(slot1),
    .rdata(dmem.rdata),
    .strobe(strobe1),
    .wdata(wdata1),
    .ldata(ldata1)
  );

  assign mem0 = is_mem(slot0.op);
  assign mem1 = is_mem(slot1.op);
  assign mem_present = mem0 | mem1;

  assign dmem.valid = mem_present & ~clear;
  assign stall = mem_present & ~clear & ~dmem.ready;
  assign complete = (~mem_present | dmem.ready) & ~clear;

  // the first cycle goes straight from the slot, later cycles from the captured copy
  always_comb begin
    if (state == mem_stage_pkg::st_wait) begin
      dmem.addr = req_addr;
      dmem.wdata = req_wdata;
      dmem.strobe = req_strobe;
    end else if (mem0) begin
      dmem.addr = slot0.address;
      dmem.wdata = wdata0;
      dmem.strobe = strobe0;
    end else begin
      dmem.addr = slot1.address;
      dmem.wdata = wdata1;
      dmem.strobe = strobe1;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      mem_stage_pkg::st_idle: begin
        if (dmem.valid & ~dmem.ready) begin
          state_next = mem_stage_pkg::st_wait;
        end
      end
      default: begin
        if (dmem.ready) begin
          state_next = mem_stage_pkg::st_idle;
        end
      end
    endcase
    if (clear) begin
      state_next = mem_stage_pkg::st_idle;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state <= mem_stage_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (state == mem_stage_pkg::st_idle) begin
      req_addr <= dmem.addr;
      req_wdata <= dmem.wdata;
      req_strobe <= dmem.strobe;
    end
  end

  assign write0 = build_write(slot0, ldata0, complete);
  assign write1 = build_write(slot1, ldata1, complete);

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module register_file (
  input logic clock,
  input logic reset,
  input mem_stage_pkg::reg_write_t write0,
  input mem_stage_pkg::reg_write_t write1,
  input mem_stage_pkg::reg_addr_t rd_addr,
  output mem_stage_pkg::xlen_t rd_data
);

  mem_stage_pkg::xlen_t regs [`MEM_REGS];

  logic wr0_ok;
  logic wr1_ok;

  assign wr0_ok = write0.wren & (write0.waddr != '0); // x0 is never written
  assign wr1_ok = write1.wren & (write1.waddr != '0);

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      for (int i = 0; i < `MEM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr0_ok) begin
        regs[write0.waddr] <= write0.wdata;
      end
      if (wr1_ok) begin
        regs[write1.waddr] <= write1.wdata; // later assignment, so slot 1 wins a tie
      end
    end
  end

  assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

//--- src.f
+incdir+hdl
hdl/mem_stage_pkg.sv
hdl/dmem_if.sv
hdl/load_store_align.sv
hdl/memory_stage.sv
hdl/data_ram.sv
hdl/register_file.sv
hdl/mem_subsystem_top.sv
test/tb_mem_subsystem.sv

//--- test/tb_mem_subsystem.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_subsystem;

  localparam int half_period = 20;
  localparam int mem_bytes = `MEM_DEPTH_WORDS * 4;
  localparam int wait_limit = 20;

  logic clock;
  logic reset;
  logic [3:0] slot0_op;
  logic [4:0] slot0_waddr;
  logic [31:0] slot0_address;
  logic [31:0] slot0_data;
  logic [3:0] slot1_op;
  logic [4:0] slot1_waddr;
  logic [31:0] slot1_address;
  logic [31:0] slot1_data;
  logic clear;
  logic [4:0] rd_addr;
  logic stall;
  logic [31:0] rd_data;

  logic [31:0] lfsr;
  logic [31:0] ref_regs [32];
  logic [7:0] ref_mem [mem_bytes];
  int checks;
  int errors;
  int test_errors;
  logic [31:0] addr_a;
  logic [31:0] addr_b;

  mem_subsystem_top i_dut (
    .clock(clock),
    .reset(reset),
    .slot0_op(slot0_op),
    .slot0_waddr(slot0_waddr),
    .slot0_address(slot0_address),
    .slot0_data(slot0_data),
    .slot1_op(slot1_op),
    .slot1_waddr(slot1_waddr),
    .slot1_address(slot1_address),
    .slot1_data(slot1_data),
    .clear(clear),
    .rd_addr(rd_addr),
    .stall(stall),
    .rd_data(rd_data)
  );

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  // galois lfsr, one step per bit handed out
  function automatic logic [31:0] random_bits(int count);
    logic [31:0] result;
    result = '0;
    for (int i = 0; i < count; i++) begin
      result = {result[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
    end
    return result;
  endfunction

  function automatic logic is_mem_op(logic [3:0] op);
    return op inside {mem_stage_pkg::op_lb, mem_stage_pkg::op_lh, mem_stage_pkg::op_lw,
                      mem_stage_pkg::op_lbu, mem_stage_pkg::op_lhu, mem_stage_pkg::op_sb,
                      mem_stage_pkg::op_sh, mem_stage_pkg::op_sw};
  endfunction

  function automatic logic is_load_op(mem_stage_pkg::mem_op_t op);
    return op inside {mem_stage_pkg::op_lb, mem_stage_pkg::op_lh, mem_stage_pkg::op_lw,
                      mem_stage_pkg::op_lbu, mem_stage_pkg::op_lhu};
  endfunction

  // byte address wraps at the memory size, lanes come from the low bits
  function automatic logic [31:0] expected_load(mem_stage_pkg::mem_op_t op, logic [31:0] addr);
    logic [31:0] a;
    logic [31:0] base;
    logic [7:0] b;
    logic [15:0] h;
    logic [31:0] w;
    a = addr % mem_bytes;
    base = a & ~32'd3;
    b = ref_mem[a];
    h = {ref_mem[(a & ~32'd1) + 1], ref_mem[a & ~32'd1]};
    w = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
    case (op)
      mem_stage_pkg::op_lb: return {{24{b[7]}}, b};
      mem_stage_pkg::op_lbu: return {24'd0, b};
      mem_stage_pkg::op_lh: return {{16{h[15]}}, h};
      mem_stage_pkg::op_lhu: return {16'd0, h};
      default: return w;
    endcase
  endfunction

  task automatic model_store(input mem_stage_pkg::mem_op_t op, input logic [31:0] addr,
                             input logic [31:0] data);
    logic [31:0] a;
    a = addr % mem_bytes;
    if (op == mem_stage_pkg::op_sb) begin
      ref_mem[a] = data[7:0];
    end else if (op == mem_stage_pkg::op_sh) begin
      ref_mem[a & ~32'd1] = data[7:0];
      ref_mem[(a & ~32'd1) + 1] = data[15:8];
    end else if (op == mem_stage_pkg::op_sw) begin
      for (int k = 0; k < 4; k++) begin
        ref_mem[(a & ~32'd3) + k] = data[8*k +: 8];
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED at time %0t: %s expected %h, actual %h",
               $time, name, expected, actual);
    end
  endtask

  task automatic drive_slot(input bit which, input mem_stage_pkg::mem_op_t op,
                            input logic [4:0] waddr, input logic [31:0] addr,
                            input logic [31:0] data);
    if (which == 1'b0) begin
      slot0_op = op;
      slot0_waddr = waddr;
      slot0_address = addr;
      slot0_data = data;
    end else begin
      slot1_op = op;
      slot1_waddr = waddr;
      slot1_address = addr;
      slot1_data = data;
    end
  endtask

  task automatic idle_slots();
    drive_slot(1'b0, mem_stage_pkg::op_none, '0, '0, '0);
    drive_slot(1'b1, mem_stage_pkg::op_none, '0, '0, '0);
  endtask

  // called on a falling edge, leaves on the next one
  task automatic check_reg(input logic [4:0] index);
    rd_addr = index;
    #1;
    check_value($sformatf("rd_data[x%0d]", index), ref_regs[index], rd_data);
    @(negedge clock);
  endtask

  task automatic alu_pair(input logic [4:0] wa0, input logic [31:0] d0,
                          input logic [4:0] wa1, input logic [31:0] d1);
    @(negedge clock);
    drive_slot(1'b0, mem_stage_pkg::op_alu, wa0, '0, d0);
    drive_slot(1'b1, mem_stage_pkg::op_alu, wa1, '0, d1);
    #1;
    check_value("stall", 32'd0, stall);
    @(negedge clock);
    idle_slots();
    if (wa0 != 0) begin
      ref_regs[wa0] = d0;
    end
    if (wa1 != 0) begin
      ref_regs[wa1] = d1; // applied last, slot 1 keeps a shared register
    end
    check_reg(wa0);
    check_reg(wa1);
  endtask

  // one memory op, with an optional alu op in the other slot that must wait for it
  task automatic access(input mem_stage_pkg::mem_op_t op, input logic [4:0] waddr,
                        input logic [31:0] addr, input logic [31:0] data, input bit mem_slot,
                        input logic [4:0] alu_waddr, input logic [31:0] alu_data);
    int stalls;
    stalls = 0;
    @(negedge clock);
    drive_slot(mem_slot, op, waddr, addr, data);
    drive_slot(!mem_slot, (alu_waddr != 0) ? mem_stage_pkg::op_alu : mem_stage_pkg::op_none,
               alu_waddr, '0, alu_data);
    rd_addr = alu_waddr;
    #1;
    while (stall === 1'b1 && stalls < wait_limit) begin
      check_value("rd_data before completion", ref_regs[alu_waddr], rd_data);
      stalls++;
      @(negedge clock);
      #1;
    end
    if (stalls >= wait_limit) begin
      errors++;
      $display("timeout at time %0t: stall never dropped for a memory access", $time);
    end
    check_value("rd_data before completion", ref_regs[alu_waddr], rd_data);
    check_value("stall cycles", `MEM_WAIT_CYCLES, stalls);
    @(negedge clock);
    idle_slots();
    if (mem_slot && alu_waddr != 0) begin
      ref_regs[alu_waddr] = alu_data;
    end
    if (is_load_op(op) && waddr != 0) begin
      ref_regs[waddr] = expected_load(op, addr);
    end
    if (!mem_slot && alu_waddr != 0) begin
      ref_regs[alu_waddr] = alu_data;
    end
    model_store(op, addr, data);
    if (is_load_op(op)) begin
      check_reg(waddr);
    end
    if (alu_waddr != 0) begin
      check_reg(alu_waddr);
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // without a memory op in either slot the stage never stalls
  always @(posedge clock) begin
    if (reset && !is_mem_op(slot0_op) && !is_mem_op(slot1_op)) begin
      assert (stall === 1'b0) else begin
        errors++;
        $display("CHECK FAILED at time %0t: stall expected 0, actual %b", $time, stall);
      end
    end
  end

  initial begin
    lfsr = 32'h1f37_48b3;
    checks = 0;
    errors = 0;
    test_errors = 0;
    reset = 1'b0;
    clear = 1'b0;
    rd_addr = '0;
    idle_slots();
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < mem_bytes; i++) begin
      ref_mem[i] = '0;
    end
    repeat (10) @(negedge clock);
    reset = 1'b1;
    #1;
    check_value("stall", 32'd0, stall);

    alu_pair(5'd1, random_bits(32), 5'd2, random_bits(32));
    alu_pair(5'd31, random_bits(32), 5'd17, random_bits(32));
    finish_test("test 1 alu pair");

    addr_a = random_bits(32) & ~32'd3;
    addr_b = addr_a ^ 32'h10; // a different word of the same memory
    access(mem_stage_pkg::op_sw, 5'd0, addr_a, random_bits(32), 1'b0, 5'd0, '0);
    access(mem_stage_pkg::op_lw, 5'd3, addr_a, '0, 1'b0, 5'd0, '0);
    finish_test("test 2 store and load word");

    access(mem_stage_pkg::op_sw, 5'd0, addr_b, random_bits(32), 1'b0, 5'd0, '0);
    for (int lane = 0; lane < 4; lane++) begin
      access(mem_stage_pkg::op_sb, 5'd0, addr_b + lane, random_bits(32), 1'b0, 5'd0, '0);
      access(mem_stage_pkg::op_lw, 5'd4, addr_b, '0, 1'b0, 5'd0, '0);
      access(mem_stage_pkg::op_lb, 5'd5, addr_b + lane, '0, 1'b0, 5'd0, '0);
      access(mem_stage_pkg::op_lbu, 5'd6, addr_b + lane, '0, 1'b0, 5'd0, '0);
    end
    for (int lane = 0; lane < 4; lane += 2) begin
      access(mem_stage_pkg::op_sh, 5'd0, addr_b + lane, random_bits(32), 1'b0, 5'd0, '0);
      access(mem_stage_pkg::op_lw, 5'd4, addr_b, '0, 1'b0, 5'd0, '0);
      access(mem_stage_pkg::op_lh, 5'd5, addr_b + lane, '0, 1'b0, 5'd0, '0);
      access(mem_stage_pkg::op_lhu, 5'd6, addr_b + lane, '0, 1'b0, 5'd0, '0);
    end
    finish_test("test 3 byte and half lanes");

    alu_pair(5'd0, random_bits(32), 5'd8, random_bits(32));
    alu_pair(5'd7, random_bits(32), 5'd7, random_bits(32));
    finish_test("test 4 x0 and shared register");

    alu_pair(5'd10, random_bits(32), 5'd0, '0);
    access(mem_stage_pkg::op_lw, 5'd9, addr_a, '0, 1'b0, 5'd10, random_bits(32));
    finish_test("test 5 alu waits for memory");

    @(negedge clock);
    drive_slot(1'b0, mem_stage_pkg::op_lw, 5'd12, addr_a, '0);
    rd_addr = 5'd12;
    repeat (`MEM_WAIT_CYCLES) begin
      #1;
      check_value("stall", 32'd1, stall);
      @(negedge clock);
    end
    clear = 1'b1; // lands on the cycle that would have brought ready
    #1;
    check_value("stall", 32'd0, stall); // clear kills the request in its own cycle
    @(negedge clock);
    clear = 1'b0;
    idle_slots();
    #1;
    check_value("stall", 32'd0, stall);
    check_value("rd_data[x12]", ref_regs[12], rd_data);
    access(mem_stage_pkg::op_sw, 5'd0, addr_a, random_bits(32), 1'b1, 5'd14, random_bits(32));
    access(mem_stage_pkg::op_lw, 5'd11, addr_a, '0, 1'b1, 5'd13, random_bits(32));
    finish_test("test 6 clear and slot 1 memory");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
